// File: Makefile
TOP_TB  = vfxp_scale_unit_tb
TOP_RTL = vfxp_scale_unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP_RTL)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP_TB) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP_TB))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: filelist.f
+incdir+include
rtl/vfxp_pkg.sv
rtl/scale_shift.sv
rtl/fxp_round.sv
rtl/mask_merge.sv
rtl/vfxp_scale_unit.sv
sim/vfxp_scale_unit_tb.sv

// File: rtl/fxp_round.sv
`timescale 1ns/1ps
`default_nettype none

module fxp_round
	import vfxp_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       s1_valid,
	input  shift_res_t s1,
	output logic       s2_valid,
	output round_res_t s2
);

	// lanes that open an element
	logic [DW_B-1:0]       start;
	// increment per lane
	logic [DW_B-1:0]       r;
	logic [DATA_WIDTH-1:0] sum;

	always_comb begin
		start = elem_start(s1.sew);
		case (s1.vxrm)
			// round to nearest up
			rnu: r = s1.rb.v_d1;
			// nearest even, ties go to even lsb
			rne: r = s1.rb.v_d1 & (s1.rb.v_d10 | s1.rb.v_d);
			// truncate
			rdn: r = '0;
			// jam into lsb when anything was shifted out
			rod: r = ~s1.rb.v_d & (s1.rb.v_d1 | s1.rb.v_d10);
			default: r = '0;
		endcase
	end

	// byte-wise ripple add, chain cut at element starts
	always_comb begin
		logic           carry;
		logic [BYTE:0]  lane;
		carry = 1'b0;
		for (int i = 0; i < DW_B; i++) begin
			lane = {1'b0, s1.vec[i*BYTE +: BYTE]}
				+ {{BYTE{1'b0}}, r[i]}
				+ {{BYTE{1'b0}}, carry & ~start[i]};
			sum[i*BYTE +: BYTE] = lane[BYTE-1:0];
			// carry out of the top lane of an element is dropped here
			carry = lane[BYTE];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s2_valid <= 1'b0;
		end else begin
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			s2.vec    <= sum;
			s2.vd_old <= s1.vd_old;
			s2.mask   <= s1.mask;
			s2.sew    <= s1.sew;
		end
	end

	// shifter must only place round bits in element start lanes
	a_rb_in_start_lane: assert property (
		@(posedge clk) disable iff (!rst_n)
		s1_valid |-> (((s1.rb.v_d | s1.rb.v_d1 | s1.rb.v_d10) & ~start) == '0)
	);

endmodule

`default_nettype wire

// File: rtl/mask_merge.sv
`timescale 1ns/1ps
`default_nettype none

module mask_merge
	import vfxp_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  s2_valid,
	input  round_res_t            s2,
	output logic                  out_valid,
	output logic [DATA_WIDTH-1:0] vec_out
);

	logic [DATA_WIDTH-1:0] merged;

	// lane i belongs to element i >> sew
	always_comb begin
		for (int i = 0; i < DW_B; i++) begin
			if (s2.mask[i >> s2.sew]) begin
				merged[i*BYTE +: BYTE] = s2.vec[i*BYTE +: BYTE];
			end else begin
				// masked off, keep old destination
				merged[i*BYTE +: BYTE] = s2.vd_old[i*BYTE +: BYTE];
			end
		end
	end

	// output reads zero between words
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			vec_out   <= '0;
		end else begin
			out_valid <= s2_valid;
			vec_out   <= s2_valid ? merged : '0;
		end
	end

	a_idle_zero: assert property (
		@(posedge clk) disable iff (!rst_n) !out_valid |-> (vec_out == '0)
	);

endmodule

`default_nettype wire

// File: rtl/scale_shift.sv
`timescale 1ns/1ps
`default_nettype none

module scale_shift
	import vfxp_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	input  vfxp_req_t  req,
	output logic       s1_valid,
	output shift_res_t s1
);

	// shifted word and round bits for every element width
	logic [SEW_N-1:0][DATA_WIDTH-1:0] vec_sew;
	logic [SEW_N-1:0][DW_B-1:0]       vd_sew;
	logic [SEW_N-1:0][DW_B-1:0]       vd1_sew;
	logic [SEW_N-1:0][DW_B-1:0]       vd10_sew;

	// picked by sew
	logic [DATA_WIDTH-1:0] sel_vec;
	round_bits_t           sel_rb;

	for (genvar i = 0; i < SEW_N; i++) begin : g_sew
		// element width, lanes per element, shift bits used
		localparam int EW = BYTE << i;
		localparam int LN = 1 << i;
		localparam int DB = $clog2(EW);

		for (genvar j = 0; j < DW_B / LN; j++) begin : g_elem
			logic [EW-1:0]   src;
			logic [DB-1:0]   d;
			logic [DB-1:0]   d_m1;
			logic [2*EW-1:0] ext;
			logic [EW-1:0]   below;
			logic            sign;
			logic            nz;
			logic            lsb;
			logic            half;
			logic            sticky;

			always_comb begin
				src  = req.vec[j*EW +: EW];
				// only the low log2(sew) bits of the scalar count
				d    = req.shift[DB-1:0];
				d_m1 = d - 1'b1;
				// sign fill only for vssra
				sign = req.arith & src[EW-1];
				ext  = {{EW{sign}}, src} >> d;
				// bits d-1 down to 0
				below  = (EW'(1) << d) - EW'(1);
				nz     = (d != '0);
				lsb    = nz & src[d];
				half   = nz & src[d_m1];
				// drop the half bit from the sticky mask
				sticky = |(src & (below >> 1));
			end

			assign vec_sew[i][j*EW +: EW] = ext[EW-1:0];
			// round bits sit in the element's lowest lane
			assign vd_sew[i][j*LN +: LN]   = LN'(lsb);
			assign vd1_sew[i][j*LN +: LN]  = LN'(half);
			assign vd10_sew[i][j*LN +: LN] = LN'(sticky);
		end
	end

	// width mux
	always_comb begin
		sel_vec      = vec_sew[req.sew];
		sel_rb.v_d   = vd_sew[req.sew];
		sel_rb.v_d1  = vd1_sew[req.sew];
		sel_rb.v_d10 = vd10_sew[req.sew];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
		end
	end

	// payload only moves with a valid word
	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1.vec    <= sel_vec;
			s1.rb     <= sel_rb;
			s1.vd_old <= req.vd_old;
			s1.mask   <= req.mask;
			s1.sew    <= req.sew;
			s1.vxrm   <= req.vxrm;
		end
	end

	// valid must be clean once out of reset
	a_s1_valid_known: assert property (
		@(posedge clk) disable iff (!rst_n) !$isunknown(s1_valid)
	);

endmodule

`default_nettype wire

// File: rtl/vfxp_pkg.sv
`default_nettype none

package vfxp_pkg;

	// datapath geometry
	localparam int DATA_WIDTH = 64;
	localparam int BYTE       = 8;
	localparam int DW_B       = DATA_WIDTH / BYTE;
	// one entry per supported element width
	localparam int SEW_N      = 4;
	localparam int SHIFT_W    = 6;

	// element width select
	typedef enum logic [1:0] {
		e8  = 2'd0,
		e16 = 2'd1,
		e32 = 2'd2,
		e64 = 2'd3
	} sew_e;

	// fixed-point rounding mode, encoded as the vxrm csr
	typedef enum logic [1:0] {
		rnu = 2'd0,
		rne = 2'd1,
		rdn = 2'd2,
		rod = 2'd3
	} vxrm_e;

	// request as it enters the unit
	typedef struct packed {
		logic [DATA_WIDTH-1:0] vec;
		logic [DATA_WIDTH-1:0] vd_old;
		logic [DW_B-1:0]       mask;
		sew_e                  sew;
		logic [SHIFT_W-1:0]    shift;
		logic                  arith;
		vxrm_e                 vxrm;
	} vfxp_req_t;

	// round bits, only the lowest lane of each element may be set
	typedef struct packed {
		logic [DW_B-1:0] v_d;
		logic [DW_B-1:0] v_d1;
		logic [DW_B-1:0] v_d10;
	} round_bits_t;

	// stage 1 result
	typedef struct packed {
		logic [DATA_WIDTH-1:0] vec;
		round_bits_t           rb;
		logic [DATA_WIDTH-1:0] vd_old;
		logic [DW_B-1:0]       mask;
		sew_e                  sew;
		vxrm_e                 vxrm;
	} shift_res_t;

	// stage 2 result
	typedef struct packed {
		logic [DATA_WIDTH-1:0] vec;
		logic [DATA_WIDTH-1:0] vd_old;
		logic [DW_B-1:0]       mask;
		sew_e                  sew;
	} round_res_t;

	// lanes that open an element for the given width
	function automatic logic [DW_B-1:0] elem_start(input sew_e sew);
		logic [DW_B-1:0] st;
		for (int i = 0; i < DW_B; i++) begin
			st[i] = ((i & ((1 << sew) - 1)) == 0);
		end
		return st;
	endfunction

endpackage

`default_nettype wire

// File: rtl/vfxp_scale_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vfxp_scale_unit
	import vfxp_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  vfxp_req_t             req,
	output logic                  out_valid,
	output logic [DATA_WIDTH-1:0] vec_out
);

	// stage links
	logic       s1_valid;
	shift_res_t s1;
	logic       s2_valid;
	round_res_t s2;

	// shift and round bit extraction
	scale_shift scale_shift_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.req      (req),
		.s1_valid (s1_valid),
		.s1       (s1)
	);

	// rounding increment
	fxp_round fxp_round_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.s1_valid (s1_valid),
		.s1       (s1),
		.s2_valid (s2_valid),
		.s2       (s2)
	);

	// mask and output register
	mask_merge mask_merge_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.s2_valid  (s2_valid),
		.s2        (s2),
		.out_valid (out_valid),
		.vec_out   (vec_out)
	);

endmodule

`default_nettype wire

// File: include/vfxp_tb_model.svh
`ifndef VFXP_TB_MODEL_SVH
`define VFXP_TB_MODEL_SVH

// one table entry with its expected output
typedef struct {
	string                 name;
	vfxp_req_t             req;
	logic [DATA_WIDTH-1:0] exp;
} vfxp_case_t;

// element by element reference for vssrl and vssra
function automatic logic [DATA_WIDTH-1:0] vfxp_model(input vfxp_req_t req);
	int                    ew;
	int                    d;
	logic [DATA_WIDTH-1:0] res;
	logic [63:0]           ones;
	logic [63:0]           src;
	logic [63:0]           q;
	logic                  lsb;
	logic                  half;
	logic                  sticky;
	logic                  r;
	ew   = BYTE << req.sew;
	d    = int'(req.shift) % ew;
	ones = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
	res  = req.vd_old;
	for (int k = 0; k < DATA_WIDTH / ew; k++) begin
		src = (req.vec >> (k * ew)) & ones;
		// sign extend for the arithmetic form
		if (req.arith && src[ew-1]) begin
			src = src | ~ones;
		end
		q      = $unsigned($signed(src) >>> d);
		lsb    = (d > 0) ? src[d] : 1'b0;
		half   = (d > 0) ? src[d-1] : 1'b0;
		sticky = (d > 1) ? |(src & ((64'd1 << (d - 1)) - 64'd1)) : 1'b0;
		case (req.vxrm)
			rnu: r = half;
			rne: r = half & (sticky | lsb);
			rdn: r = 1'b0;
			default: r = ~lsb & (half | sticky);
		endcase
		// wrap inside the element
		q = (q + 64'(r)) & ones;
		if (req.mask[k]) begin
			res = (res & ~(ones << (k * ew))) | (q << (k * ew));
		end
	end
	return res;
endfunction

`endif

// File: sim/vfxp_scale_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vfxp_scale_unit_tb
	import vfxp_pkg::*;
();

	`include "vfxp_tb_model.svh"

	localparam int CLK_PERIOD  = 20;
	localparam int DRAIN_LIMIT = 50;
	localparam int RAND_WORDS  = 32;
	// old destination for the fully masked-on entries
	localparam logic [DATA_WIDTH-1:0] OLD = 64'hDEAD_BEEF_0BAD_F00D;

	logic                  clk;
	logic                  rst_n;
	logic                  in_valid;
	vfxp_req_t             req;
	logic                  out_valid;
	logic [DATA_WIDTH-1:0] vec_out;

	// hand-written stimulus with expected results
	vfxp_case_t cases[$];

	// words in flight, oldest first
	string                 pend_name[$];
	logic [DATA_WIDTH-1:0] pend_exp[$];
	int                    pend_cyc[$];

	// word on the inputs this cycle, picked up by the monitor
	string                 cur_name;
	logic [DATA_WIDTH-1:0] cur_exp;

	int cycle   = 0;
	int n_tests = 0;
	int n_pass  = 0;
	int n_fail  = 0;
	int n_err   = 0;
	int seed;

	vfxp_scale_unit vfxp_scale_unit_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.req       (req),
		.out_valid (out_valid),
		.vec_out   (vec_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// rising edges seen so far
	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic add_case(input string name, input logic [DATA_WIDTH-1:0] vec,
		input logic [DATA_WIDTH-1:0] vd_old, input logic [DW_B-1:0] mask, input sew_e sew,
		input logic [SHIFT_W-1:0] shift, input logic arith, input vxrm_e vxrm,
		input logic [DATA_WIDTH-1:0] exp);
		vfxp_case_t c;
		c.name       = name;
		c.req.vec    = vec;
		c.req.vd_old = vd_old;
		c.req.mask   = mask;
		c.req.sew    = sew;
		c.req.shift  = shift;
		c.req.arith  = arith;
		c.req.vxrm   = vxrm;
		c.exp        = exp;
		cases.push_back(c);
	endtask

	task automatic load_table();
		// sew8 logical, d = 2, lanes cover lsb/half/sticky combos incl. ties
		add_case("sew8_srl_rnu", 64'hFF05_0706_0302_0100, OLD, 8'hFF, e8, 6'd2, 1'b0, rnu,
			64'h4001_0202_0101_0000);
		add_case("sew8_srl_rne", 64'hFF05_0706_0302_0100, OLD, 8'hFF, e8, 6'd2, 1'b0, rne,
			64'h4001_0202_0100_0000);
		add_case("sew8_srl_rdn", 64'hFF05_0706_0302_0100, OLD, 8'hFF, e8, 6'd2, 1'b0, rdn,
			64'h3F01_0101_0000_0000);
		// amount 10 wraps to 2 at sew8
		add_case("sew8_srl_rod", 64'hFF05_0706_0302_0100, OLD, 8'hFF, e8, 6'd10, 1'b0, rod,
			64'h3F01_0101_0101_0100);
		// negative halves, rne ties on odd and even lsb
		add_case("sew16_sra_rne", 64'hFF37_8000_FFE8_FFF8, OLD, 8'hFF, e16, 6'd4, 1'b1, rne,
			64'hFFF3_F800_FFFE_0000);
		add_case("sew16_sra_rnu", 64'hFF37_8000_FFE8_FFF8, OLD, 8'hFF, e16, 6'd4, 1'b1, rnu,
			64'hFFF3_F800_FFFF_0000);
		add_case("sew32_sra_rne", 64'hFFFF_FF80_FFFF_FE80, OLD, 8'hFF, e32, 6'd8, 1'b1, rne,
			64'h0000_0000_FFFF_FFFE);
		add_case("sew32_sra_rod", 64'h7FFF_FFFF_8000_0001, OLD, 8'hFF, e32, 6'd31, 1'b1, rod,
			64'h0000_0001_FFFF_FFFF);
		// zero effective shift passes elements through
		add_case("sew8_shift0", 64'h0123_4567_89AB_CDEF, OLD, 8'hFF, e8, 6'd0, 1'b1, rnu,
			64'h0123_4567_89AB_CDEF);
		add_case("sew16_shift16", 64'hFEDC_BA98_7654_3210, OLD, 8'hFF, e16, 6'd16, 1'b0, rod,
			64'hFEDC_BA98_7654_3210);
		// top bit only at sew64
		add_case("sew64_srl_63", 64'hC000_0000_0000_0001, OLD, 8'hFF, e64, 6'd63, 1'b0, rnu,
			64'h0000_0000_0000_0002);
		add_case("sew64_sra_63", 64'h8000_0000_0000_0000, OLD, 8'hFF, e64, 6'd63, 1'b1, rnu,
			64'hFFFF_FFFF_FFFF_FFFF);
		add_case("sew64_srl_63_tie", 64'h4000_0000_0000_0000, OLD, 8'hFF, e64, 6'd63, 1'b0,
			rne, 64'h0000_0000_0000_0000);
		// all-ones elements wrap to zero, zero neighbours must stay zero
		add_case("sew8_carry_mix", 64'h00FF_00FF_00FF_00FF, OLD, 8'hFF, e8, 6'd1, 1'b1, rnu,
			64'h0000_0000_0000_0000);
		add_case("sew8_carry_ones", 64'hFFFF_FFFF_FFFF_FFFF, OLD, 8'hFF, e8, 6'd1, 1'b1, rnu,
			64'h0000_0000_0000_0000);
		add_case("sew16_carry_mix", 64'h0000_FFFF_0000_FFFF, OLD, 8'hFF, e16, 6'd1, 1'b1, rnu,
			64'h0000_0000_0000_0000);
		add_case("sew32_carry_ones", 64'hFFFF_FFFF_FFFF_FFFF, OLD, 8'hFF, e32, 6'd1, 1'b1,
			rnu, 64'h0000_0000_0000_0000);
		add_case("sew64_carry_ones", 64'hFFFF_FFFF_FFFF_FFFF, OLD, 8'hFF, e64, 6'd1, 1'b1,
			rnu, 64'h0000_0000_0000_0000);
		// masked-off elements keep vd_old, upper mask bits ignored at wide sew
		add_case("sew8_mask", 64'h0303_0303_0303_0303, 64'h1122_3344_5566_7788, 8'hA5, e8,
			6'd1, 1'b0, rnu, 64'h0222_0244_5502_7702);
		add_case("sew32_mask", 64'h0000_0030_0000_0030, 64'hAAAA_BBBB_CCCC_DDDD, 8'hFE, e32,
			6'd4, 1'b0, rne, 64'h0000_0003_CCCC_DDDD);
		add_case("sew16_mask", 64'h0100_0100_0100_0100, 64'h1111_2222_3333_4444, 8'h04, e16,
			6'd9, 1'b0, rnu, 64'h1111_0001_3333_4444);
	endtask

	task automatic send_word(input string name, input vfxp_req_t r,
		input logic [DATA_WIDTH-1:0] exp);
		@(posedge clk);
		in_valid <= 1'b1;
		req      <= r;
		cur_name = name;
		cur_exp  = exp;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	// compare one returned word with the oldest word in flight
	task automatic check_word();
		string                 name;
		logic [DATA_WIDTH-1:0] exp;
		int                    issued;
		if (pend_exp.size() == 0) begin
			$display("ERROR: out_valid high at cycle %0d with no word in flight", cycle);
			n_err++;
			return;
		end
		name   = pend_name.pop_front();
		exp    = pend_exp.pop_front();
		issued = pend_cyc.pop_front();
		n_tests++;
		if (cycle - issued != 3) begin
			$display("ERROR: %s came out %0d cycles after issue, not 3", name, cycle - issued);
			n_err++;
		end
		if (vec_out !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, vec_out);
			n_fail++;
		end else begin
			$display("[PASS] %s %h", name, vec_out);
			n_pass++;
		end
	endtask

	// sample away from the rising edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				check_word();
			end else if (vec_out !== '0) begin
				$display("ERROR: vec_out is %h while out_valid is low at cycle %0d",
					vec_out, cycle);
				n_err++;
			end
			if (in_valid) begin
				pend_name.push_back(cur_name);
				pend_exp.push_back(cur_exp);
				pend_cyc.push_back(cycle);
			end
		end
	end

	initial begin
		vfxp_req_t   rq;
		logic [31:0] rnd;
		int          guard;
		seed     = 32'he211_d247;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		req      = '0;
		cur_name = "";
		cur_exp  = '0;
		load_table();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		idle_cycles(2);
		// table words back to back
		foreach (cases[i]) begin
			send_word(cases[i].name, cases[i].req, cases[i].exp);
		end
		idle_cycles(3);
		// random words with occasional gaps
		for (int i = 0; i < RAND_WORDS; i++) begin
			rq.vec[63:32]    = $random(seed);
			rq.vec[31:0]     = $random(seed);
			rq.vd_old[63:32] = $random(seed);
			rq.vd_old[31:0]  = $random(seed);
			rnd              = $random(seed);
			rq.mask          = rnd[7:0];
			rq.sew           = sew_e'(rnd[9:8]);
			rq.shift         = rnd[15:10];
			rq.arith         = rnd[16];
			rq.vxrm          = vxrm_e'(rnd[18:17]);
			send_word($sformatf("rand_%02d", i), rq, vfxp_model(rq));
			if (rnd[21:20] == 2'b00) begin
				idle_cycles(1 + int'(rnd[23:22]));
			end
		end
		idle_cycles(1);
		// let the pipe drain
		guard = 0;
		while (pend_exp.size() > 0 && guard < DRAIN_LIMIT) begin
			@(posedge clk);
			guard++;
		end
		if (pend_exp.size() > 0) begin
			$display("ERROR: timeout, %0d words never came out", pend_exp.size());
			n_err++;
		end
		$display("tests %0d, passed %0d, failed %0d, other errors %0d",
			n_tests, n_pass, n_fail, n_err);
		if (n_fail == 0 && n_err == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// hard limit on run time
	initial begin
		#(CLK_PERIOD * 5000);
		$display("ERROR: simulation ran past its time limit");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
